//--- rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Datapath widths
    typedef logic [31:0] u32_t;
    typedef logic [31:0] virt_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_idx_t;

    // Instruction queue sizing
    localparam int IQ_DEPTH = 4;
    localparam int IQ_CNT_W = $clog2(IQ_DEPTH + 1);
    localparam int IQ_PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;

    typedef logic [IQ_CNT_W-1:0] iq_cnt_t;
    typedef logic [IQ_PTR_W-1:0] iq_ptr_t;

    // Occupancy of a full queue, also the starting credit count
    localparam iq_cnt_t IQ_FULL = iq_cnt_t'(IQ_DEPTH);

    localparam virt_t RESET_PC = 32'h1c000000;

    // LA32R opcode fields

    // Bits 31 to 22
    localparam logic [9:0]  OP_ADDI_W = 10'b0000001010;
    // Bits 31 to 15
    localparam logic [16:0] OP_ADD_W  = 17'b00000000000100000;
    // Bits 31 to 26
    localparam logic [5:0]  OP_BEQ    = 6'b010110;
    localparam logic [5:0]  OP_B      = 6'b010100;

    // One outstanding icache request at a time
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_DROP
    } fetch_state_t;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  icache_ready,
    input  inst_t icache_data,
    output logic  icache_req,
    output virt_t icache_pa,
    output logic  iq_push,
    output virt_t iq_pc,
    output inst_t iq_inst,
    input  logic  credit_return,
    input  logic  redirect,
    input  virt_t redirect_pc
);

    fetch_state_t state;
    virt_t        pc;
    virt_t        req_pa;
    iq_cnt_t      credits;
    logic         start;

    // Only ask the icache when the queue has promised a slot
    assign start = (state == FETCH_IDLE) && (credits != '0) && !redirect;

    assign icache_req = (state != FETCH_IDLE);
    assign icache_pa  = req_pa;

    // Answer is dropped if a redirect lands in the same cycle
    assign iq_push = (state == FETCH_WAIT) && icache_ready && !redirect;
    assign iq_pc   = req_pa;
    assign iq_inst = icache_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_IDLE;
        end else begin
            unique case (state)
                FETCH_IDLE: begin
                    if (start) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (icache_ready) begin
                        state <= FETCH_IDLE;
                    end else if (redirect) begin
                        state <= FETCH_DROP;
                    end
                end
                FETCH_DROP: begin
                    if (icache_ready) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc     <= RESET_PC;
            req_pa <= RESET_PC;
        end else begin
            if (redirect) begin
                pc <= redirect_pc;
            end else if (iq_push) begin
                pc <= pc + 32'd4;
            end
            if (start) begin
                req_pa <= pc;
            end
        end
    end

    // Queue is emptied on redirect so every slot is free again
    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            credits <= IQ_FULL;
        end else begin
            case ({iq_push, credit_return})
                2'b10:   credits <= credits - iq_cnt_t'(1);
                2'b01:   credits <= credits + iq_cnt_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    credit_bound_a: assert property (@(posedge clk) disable iff (rst)
        credits <= IQ_FULL);

    pa_stable_a: assert property (@(posedge clk) disable iff (rst)
        icache_req && !icache_ready |=> icache_req && $stable(icache_pa));

endmodule

`default_nettype wire

//--- rtl/inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

module inst_queue
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  iq_push,
    input  virt_t iq_pc,
    input  inst_t iq_inst,
    input  logic  iq_pop,
    input  logic  redirect,
    output logic  iq_valid,
    output virt_t iq_head_pc,
    output inst_t iq_head_inst,
    output logic  credit_return
);

    virt_t   pc_mem   [IQ_DEPTH];
    inst_t   inst_mem [IQ_DEPTH];
    iq_ptr_t wr_ptr;
    iq_ptr_t rd_ptr;
    iq_cnt_t count;
    logic    do_pop;

    function automatic iq_ptr_t ptr_inc(input iq_ptr_t p);
        return (p == iq_ptr_t'(IQ_DEPTH - 1)) ? '0 : p + iq_ptr_t'(1);
    endfunction

    assign iq_valid     = (count != '0);
    assign do_pop       = iq_pop && iq_valid;
    assign iq_head_pc   = pc_mem[rd_ptr];
    assign iq_head_inst = inst_mem[rd_ptr];

    // One credit back to fetch for each slot freed
    assign credit_return = do_pop;

    always_ff @(posedge clk) begin
        if (iq_push) begin
            pc_mem[wr_ptr]   <= iq_pc;
            inst_mem[wr_ptr] <= iq_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (iq_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({iq_push, do_pop})
                2'b10:   count <= count + iq_cnt_t'(1);
                2'b01:   count <= count - iq_cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // Fetch credits must keep pushes away from a full queue
    no_push_full_a: assert property (@(posedge clk) disable iff (rst)
        iq_push |-> count != IQ_FULL);

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rj,
    input  reg_idx_t rkd,
    output u32_t     rj_data,
    output u32_t     rkd_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  u32_t     rd_data
);

    // r0 has no storage
    u32_t regs [1:31];

    assign rj_data  = (rj == '0) ? '0 : regs[rj];
    assign rkd_data = (rkd == '0) ? '0 : regs[rkd];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= rd_data;
        end
    end

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       hold,

    input  logic       iq_valid,
    input  virt_t      iq_head_pc,
    input  inst_t      iq_head_inst,
    output logic       iq_pop,

    output reg_idx_t   rj,
    output reg_idx_t   rkd,
    input  u32_t       rj_data,
    input  u32_t       rkd_data,
    output logic       reg_we,
    output reg_idx_t   rd,
    output u32_t       rd_data,

    output logic       redirect,
    output virt_t      redirect_pc,

    output u32_t       debug0_wb_pc,
    output logic [3:0] debug0_wb_rf_wen,
    output reg_idx_t   debug0_wb_rf_wnum,
    output u32_t       debug0_wb_rf_wdata,
    output inst_t      debug0_wb_inst
);

    logic     fire;
    logic     is_addi;
    logic     is_add;
    logic     is_beq;
    logic     is_b;
    logic     writes_rd;
    logic     taken;
    reg_idx_t rd_f;
    reg_idx_t rk_f;
    u32_t     si12_ext;
    virt_t    br_offs;
    u32_t     result;

    // Retire the head whenever one is there and nothing holds us
    assign fire   = iq_valid && !hold;
    assign iq_pop = fire;

    assign is_addi = (iq_head_inst[31:22] == OP_ADDI_W);
    assign is_add  = (iq_head_inst[31:15] == OP_ADD_W);
    assign is_beq  = (iq_head_inst[31:26] == OP_BEQ);
    assign is_b    = (iq_head_inst[31:26] == OP_B);

    assign writes_rd = is_addi || is_add;

    assign rd_f = iq_head_inst[4:0];
    assign rk_f = iq_head_inst[14:10];
    assign rj   = iq_head_inst[9:5];

    // BEQ compares against rd, so rd goes out on the second port
    assign rkd = is_beq ? rd_f : rk_f;

    assign si12_ext = {{20{iq_head_inst[21]}}, iq_head_inst[21:10]};

    always_comb begin
        if (is_b) begin
            // offs26 is split, high part sits in bits 9 to 0
            br_offs = {{4{iq_head_inst[9]}}, iq_head_inst[9:0],
                       iq_head_inst[25:10], 2'b00};
        end else begin
            br_offs = {{14{iq_head_inst[25]}}, iq_head_inst[25:10], 2'b00};
        end
    end

    assign result = is_addi ? (rj_data + si12_ext) : (rj_data + rkd_data);
    assign taken  = is_b || (is_beq && (rj_data == rkd_data));

    assign reg_we  = fire && writes_rd;
    assign rd      = rd_f;
    assign rd_data = result;

    assign redirect    = fire && taken;
    assign redirect_pc = iq_head_pc + br_offs;

    // Trace is zero between retires, a non-zero pc marks a retire
    always_ff @(posedge clk) begin
        if (rst || !fire) begin
            debug0_wb_pc       <= '0;
            debug0_wb_rf_wen   <= '0;
            debug0_wb_rf_wnum  <= '0;
            debug0_wb_rf_wdata <= '0;
            debug0_wb_inst     <= '0;
        end else begin
            debug0_wb_pc       <= iq_head_pc;
            debug0_wb_rf_wen   <= {4{writes_rd && (rd_f != '0)}};
            debug0_wb_rf_wnum  <= rd_f;
            debug0_wb_rf_wdata <= result;
            debug0_wb_inst     <= iq_head_inst;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top
    import cpu_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       hold,

    output logic       icache_req,
    output virt_t      icache_pa,
    input  logic       icache_ready,
    input  inst_t      icache_data,

    output u32_t       debug0_wb_pc,
    output logic [3:0] debug0_wb_rf_wen,
    output reg_idx_t   debug0_wb_rf_wnum,
    output u32_t       debug0_wb_rf_wdata,
    output inst_t      debug0_wb_inst
);

    // Fetch to queue
    logic  iq_push;
    virt_t iq_pc;
    inst_t iq_inst;
    logic  credit_return;

    // Queue to execute
    logic  iq_valid;
    virt_t iq_head_pc;
    inst_t iq_head_inst;
    logic  iq_pop;

    // Branch flush
    logic  redirect;
    virt_t redirect_pc;

    reg_idx_t rj, rkd, rd;
    u32_t     rj_data, rkd_data, rd_data;
    logic     reg_we;

    fetch_unit u_fetch_unit (
        .clk, .rst,
        .icache_ready, .icache_data, .icache_req, .icache_pa,
        .iq_push, .iq_pc, .iq_inst, .credit_return,
        .redirect, .redirect_pc
    );

    inst_queue u_inst_queue (
        .clk, .rst,
        .iq_push, .iq_pc, .iq_inst, .iq_pop, .redirect,
        .iq_valid, .iq_head_pc, .iq_head_inst, .credit_return
    );

    reg_file u_reg_file (
        .clk, .rst,
        .rj, .rkd, .rj_data, .rkd_data,
        .we(reg_we), .rd, .rd_data
    );

    exec_unit u_exec_unit (
        .clk, .rst, .hold,
        .iq_valid, .iq_head_pc, .iq_head_inst, .iq_pop,
        .rj, .rkd, .rj_data, .rkd_data, .reg_we, .rd, .rd_data,
        .redirect, .redirect_pc,
        .debug0_wb_pc, .debug0_wb_rf_wen, .debug0_wb_rf_wnum,
        .debug0_wb_rf_wdata, .debug0_wb_inst
    );

endmodule

`default_nettype wire

//--- verif/icache_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_model
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  virt_t pa,
    output logic  ready,
    output inst_t data,
    output u32_t  accepted
);

    localparam int unsigned SEED = 32'h5e78ac28;

    // Word addressed from RESET_PC and wrapping every 256 words
    inst_t mem [256];
    virt_t req_pa;
    virt_t offset;
    logic  busy;
    int    latency;

    initial begin
        void'($urandom(SEED));
        ready    = 1'b0;
        data     = '0;
        busy     = 1'b0;
        latency  = 0;
        accepted = '0;
        req_pa   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst) begin
                ready    = 1'b0;
                busy     = 1'b0;
                accepted = '0;
            end else if (ready) begin
                // Answer was taken at this edge
                ready = 1'b0;
                busy  = 1'b0;
            end else if (busy) begin
                latency = latency - 1;
                if (latency == 0) begin
                    offset = req_pa - RESET_PC;
                    data   = mem[offset[9:2]];
                    ready  = 1'b1;
                end
            end else if (req) begin
                busy     = 1'b1;
                req_pa   = pa;
                latency  = int'($urandom % 4) + 1;
                accepted = accepted + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top
    import cpu_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic       clk;
    logic       rst;
    logic       hold;
    logic       icache_req;
    virt_t      icache_pa;
    logic       icache_ready;
    inst_t      icache_data;
    u32_t       debug0_wb_pc;
    logic [3:0] debug0_wb_rf_wen;
    reg_idx_t   debug0_wb_rf_wnum;
    u32_t       debug0_wb_rf_wdata;
    inst_t      debug0_wb_inst;
    u32_t       accepted;

    // Reference model state and its prediction for the next retire
    inst_t      prog [256];
    u32_t       ref_regs [32];
    virt_t      ref_pc;
    virt_t      exp_pc;
    inst_t      exp_inst;
    reg_idx_t   exp_wnum;
    logic [3:0] exp_wen;
    u32_t       exp_wdata;
    logic       exp_has_data;

    cpu_top dut_i (.*);

    icache_model icache_i (
        .clk, .rst, .req(icache_req), .pa(icache_pa),
        .ready(icache_ready), .data(icache_data), .accepted
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_stop(string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, u32_t got, u32_t exp);
        fail_stop($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_u32(string name, u32_t got, u32_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_inst(string name, inst_t got, inst_t exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic check_idx(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) report_mismatch(name, u32_t'(got), u32_t'(exp));
    endtask

    task automatic check_wen(string name, logic [3:0] got, logic [3:0] exp);
        if (got !== exp) report_mismatch(name, u32_t'(got), u32_t'(exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) report_mismatch(name, u32_t'(got), u32_t'(exp));
    endtask

    function automatic inst_t enc_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] si12);
        return {OP_ADDI_W, si12, rj, rd};
    endfunction

    function automatic inst_t enc_add(reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {OP_ADD_W, rk, rj, rd};
    endfunction

    function automatic inst_t enc_beq(reg_idx_t rj, reg_idx_t rd, logic [15:0] offs);
        return {OP_BEQ, offs, rj, rd};
    endfunction

    // offs26 high bits go in the low field
    function automatic inst_t enc_b(logic [25:0] offs);
        return {OP_B, offs[15:0], offs[25:16]};
    endfunction

    // Executes one instruction in the reference model
    task automatic model_step();
        virt_t    off;
        virt_t    next_pc;
        inst_t    w;
        u32_t     a;
        reg_idx_t rd_i;
        off = ref_pc - RESET_PC;
        w = prog[off[9:2]];
        rd_i = w[4:0];
        a = ref_regs[w[9:5]];
        next_pc = ref_pc + 32'd4;
        exp_pc = ref_pc;
        exp_inst = w;
        exp_wnum = rd_i;
        exp_wen = 4'h0;
        exp_wdata = '0;
        exp_has_data = 1'b0;
        if (w[31:22] == OP_ADDI_W) begin
            exp_wdata = a + {{20{w[21]}}, w[21:10]};
            exp_has_data = 1'b1;
        end else if (w[31:15] == OP_ADD_W) begin
            exp_wdata = a + ref_regs[w[14:10]];
            exp_has_data = 1'b1;
        end else if (w[31:26] == OP_BEQ) begin
            if (a == ref_regs[rd_i]) next_pc = ref_pc + {{14{w[25]}}, w[25:10], 2'b00};
        end else if (w[31:26] == OP_B) begin
            next_pc = ref_pc + {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        end
        // r0 is never written
        if (exp_has_data && rd_i != '0) begin
            exp_wen = 4'hf;
            ref_regs[rd_i] = exp_wdata;
        end
        ref_pc = next_pc;
    endtask

    task automatic compare_retire();
        model_step();
        check_u32("debug0_wb_pc", debug0_wb_pc, exp_pc);
        check_inst("debug0_wb_inst", debug0_wb_inst, exp_inst);
        check_idx("debug0_wb_rf_wnum", debug0_wb_rf_wnum, exp_wnum);
        check_wen("debug0_wb_rf_wen", debug0_wb_rf_wen, exp_wen);
        if (exp_has_data) check_u32("debug0_wb_rf_wdata", debug0_wb_rf_wdata, exp_wdata);
    endtask

    // Trace is zero between retires
    task automatic wait_retire();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) fail_stop("No instruction retired within the timeout");
        end while (debug0_wb_pc == '0);
    endtask

    task automatic run_retires(int n);
        repeat (n) begin
            wait_retire();
            compare_retire();
        end
    endtask

    // Filler words decode as no-ops
    task automatic new_program();
        for (int i = 0; i < 256; i++) begin
            prog[i] = {8'hff, 16'h0000, 8'(i)};
        end
    endtask

    task automatic restart();
        for (int i = 0; i < 256; i++) begin
            icache_i.mem[i] = prog[i];
        end
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = RESET_PC;
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic load_alu_chain();
        new_program();
        prog[0] = enc_addi(5'd1, 5'd0, 12'h005);
        prog[1] = enc_addi(5'd2, 5'd1, 12'hffd);
        prog[2] = enc_add(5'd3, 5'd1, 5'd2);
        prog[3] = enc_add(5'd4, 5'd3, 5'd3);
        prog[4] = enc_addi(5'd5, 5'd4, 12'h7ff);
        prog[5] = enc_add(5'd6, 5'd5, 5'd2);
    endtask

    task automatic test_reset();
        int cycles;
        new_program();
        prog[0] = enc_addi(5'd1, 5'd0, 12'h00a);
        restart();
        @(negedge clk);
        check_bit("icache_req", icache_req, 1'b0);
        check_wen("debug0_wb_rf_wen", debug0_wb_rf_wen, 4'h0);
        cycles = 0;
        while (!icache_req) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) fail_stop("First icache request never appeared");
        end
        check_u32("icache_pa", icache_pa, RESET_PC);
        run_retires(1);
    endtask

    task automatic test_alu_chain();
        load_alu_chain();
        restart();
        run_retires(6);
    endtask

    task automatic test_branches();
        new_program();
        prog[0] = enc_addi(5'd1, 5'd0, 12'h007);
        prog[1] = enc_addi(5'd2, 5'd0, 12'h007);
        prog[2] = enc_beq(5'd1, 5'd2, 16'd3);
        prog[3] = enc_addi(5'd3, 5'd0, 12'h001);
        prog[4] = enc_addi(5'd3, 5'd0, 12'h002);
        prog[5] = enc_beq(5'd1, 5'd0, 16'd2);
        prog[6] = enc_b(26'd3);
        prog[7] = enc_addi(5'd4, 5'd0, 12'h009);
        prog[8] = enc_addi(5'd4, 5'd0, 12'h009);
        prog[9] = enc_addi(5'd5, 5'd1, 12'h001);
        restart();
        run_retires(7);
    endtask

    task automatic test_hold();
        u32_t base;
        load_alu_chain();
        restart();
        run_retires(2);
        @(posedge clk);
        #1;
        hold = 1'b1;
        base = '0;
        // A retire from the edge before hold may still show up
        for (int i = 0; i < 50; i++) begin
            @(negedge clk);
            if (i == 0) base = accepted;
            if (debug0_wb_pc != '0) compare_retire();
        end
        if (accepted - base > u32_t'(IQ_DEPTH)) fail_stop("Too many fetches accepted during hold");
        @(posedge clk);
        #1;
        hold = 1'b0;
        run_retires(3);
    endtask

    task automatic test_r0_writes();
        new_program();
        prog[0] = enc_addi(5'd0, 5'd0, 12'h005);
        prog[1] = enc_addi(5'd1, 5'd0, 12'h003);
        prog[2] = enc_add(5'd2, 5'd0, 5'd1);
        prog[3] = enc_add(5'd0, 5'd1, 5'd1);
        prog[4] = enc_addi(5'd3, 5'd0, 12'h001);
        restart();
        run_retires(5);
    endtask

    task automatic test_loop();
        new_program();
        prog[0] = enc_addi(5'd1, 5'd0, 12'h000);
        prog[1] = enc_addi(5'd2, 5'd0, 12'h006);
        prog[2] = enc_addi(5'd1, 5'd1, 12'h001);
        prog[3] = enc_add(5'd3, 5'd3, 5'd1);
        prog[4] = enc_beq(5'd1, 5'd2, 16'd2);
        prog[5] = enc_b(26'h3fffffd);
        prog[6] = enc_addi(5'd1, 5'd0, 12'h000);
        prog[7] = enc_b(26'h3fffffb);
        restart();
        run_retires(40);
    endtask

    initial begin
        rst = 1'b1;
        hold = 1'b0;
        test_reset();
        test_alu_chain();
        test_branches();
        test_hold();
        test_r0_writes();
        test_loop();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/inst_queue.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/cpu_top.sv
verif/icache_model.sv
verif/tb_cpu_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_cpu_top
FILELIST  := all.f
FLAGS     := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
